// File: src.f
+incdir+sim
hw/iris_nn_pkg.sv
hw/neuron_mac.sv
hw/sigmoid_plan.sv
hw/nn_layer.sv
hw/species_argmax.sv
hw/iris_nn_top.sv
sim/iris_nn_tb.sv

// File: Bender.yml
package:
  name: iris_nn

sources:
  - files:
      - hw/iris_nn_pkg.sv
      - hw/neuron_mac.sv
      - hw/sigmoid_plan.sv
      - hw/nn_layer.sv
      - hw/species_argmax.sv
      - hw/iris_nn_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/iris_nn_tb.sv

// File: sim/iris_nn_model.svh
`ifndef IRIS_NN_MODEL_SVH
`define IRIS_NN_MODEL_SVH

// Reference network in 1/1024 units
localparam int ref_hidden_w [4][4] = '{
    '{  4096,   152, 13805,  7032 },
    '{ -2170,  5829, -6716, -6711 },
    '{ -6373,  -260, 12796,  6749 },
    '{ -4363,   258,  8743,  4187 }
};
localparam int ref_hidden_b [4] = '{ -9996, 1373, -9279, -6392 };
localparam int ref_output_w [3][4] = '{
    '{ -3021,   8552, -4527, -3163 },
    '{ -8026, -12568, -6552, -3830 },
    '{  7231,  -4009,  7569,  5084 }
};
localparam int ref_output_b [3] = '{ -3513, 7825, -8361 };

// Piecewise-linear sigmoid, mirrored for negative input
function automatic int sigmoid_ref(input longint x);
    longint a;
    longint v;
    a = (x < 0) ? -x : x;
    if (a >= 5120) begin
        v = 1024;
    end else if (a >= 2432) begin
        v = (a >> 5) + 864;
    end else if (a >= 1024) begin
        v = (a >> 3) + 640;
    end else begin
        v = (a >> 2) + 512;
    end
    return (x < 0) ? int'(1024 - v) : int'(v);
endfunction

// Full network, species index and winning score
task automatic predict_species(input int sl, input int sw, input int pl, input int pw,
                               output int sp, output int sc);
    int     feat [4];
    int     hid [4];
    int     outp [3];
    longint acc;
    feat[0] = sl;
    feat[1] = sw;
    feat[2] = pl;
    feat[3] = pw;
    for (int j = 0; j < 4; j++) begin
        acc = ref_hidden_b[j];
        for (int i = 0; i < 4; i++) begin
            acc = acc + ((longint'(ref_hidden_w[j][i]) * (feat[i] * 1024)) >>> 10);
        end
        hid[j] = sigmoid_ref(acc);
    end
    for (int k = 0; k < 3; k++) begin
        acc = ref_output_b[k];
        for (int i = 0; i < 4; i++) begin
            acc = acc + ((longint'(ref_output_w[k][i]) * hid[i]) >>> 10);
        end
        outp[k] = sigmoid_ref(acc);
    end
    // Strict compare keeps the lower index on a tie
    sp = 0;
    sc = outp[0];
    for (int k = 1; k < 3; k++) begin
        if (outp[k] > sc) begin
            sp = k;
            sc = outp[k];
        end
    end
endtask

`endif

// File: sim/iris_nn_tb.sv
`default_nettype none

module iris_nn_tb;

    `include "iris_nn_model.svh"

    localparam int clk_period = 40;
    localparam int n_rows     = 14;
    localparam int n_random   = 200;
    // Worst-case input slots, random gaps included
    localparam int n_slots    = 4 + 3 * n_rows + 4 * n_random;

    // sl sw pl pw | species | score
    localparam logic [31:0] stim_table [n_rows] = '{
        32'h0000_03C5, 32'hFFFF_2400, 32'h1300_03FD, 32'h2200_03EB,
        32'h1100_03FC, 32'h1000_13DC, 32'h2000_1400, 32'h3000_128D,
        32'h4000_11CE, 32'h1001_1354, 32'h1010_220D, 32'h0010_2400,
        32'h0002_2400, 32'h0001_1400
    };

    logic                              clk;
    logic                              rst_n;
    logic                              in_valid;
    logic [iris_nn_pkg::feat_w-1:0]    sepal_len;
    logic [iris_nn_pkg::feat_w-1:0]    sepal_wid;
    logic [iris_nn_pkg::feat_w-1:0]    petal_len;
    logic [iris_nn_pkg::feat_w-1:0]    petal_wid;
    logic                              out_valid;
    logic [3:0]                        species;
    logic [iris_nn_pkg::prob_w-1:0]    score;

    logic [15:0] exp_q [$];
    int          sent_q [$];
    int          cyc = 0;
    int          errors = 0;
    int          errors_before = 0;
    int          n_checked = 0;
    int          n_out_seen = 0;
    int          seen_before;
    int          gap;
    integer      seed = 56;
    logic [15:0] model_val;
    logic [15:0] rand_feat;

    iris_nn_top i_dut (
        .clk (clk), .rst_n (rst_n), .in_valid (in_valid),
        .sepal_len (sepal_len), .sepal_wid (sepal_wid),
        .petal_len (petal_len), .petal_wid (petal_wid),
        .out_valid (out_valid), .species (species), .score (score)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #((n_slots + iris_nn_pkg::total_latency + 20) * 2 * clk_period);
        $display("Error: watchdog expired before the tests ended");
        $display("Finished with errors");
        $finish;
    end

    ////////////////////
    // Output monitor

    always @(negedge clk) begin : monitor
        logic [15:0] exp_val;
        int          sent_at;
        if (out_valid) begin
            n_out_seen++;
            if (exp_q.size() == 0) begin
                $display("Error: out_valid went high with no item in flight at cycle %0d", cyc);
                errors++;
            end else begin
                exp_val = exp_q.pop_front();
                sent_at = sent_q.pop_front();
                assert (species == exp_val[15:12]) else begin
                    $display("Fail: species expected %h, got %h", exp_val[15:12], species);
                    errors++;
                end
                assert (score == exp_val[10:0]) else begin
                    $display("Fail: score expected %h, got %h", exp_val[10:0], score);
                    errors++;
                end
                assert (cyc - sent_at == iris_nn_pkg::total_latency) else begin
                    $display("Error: item arrived %0d cycles after its strobe", cyc - sent_at);
                    errors++;
                end
                n_checked++;
            end
        end
    end

    ////////////////////
    // Stimulus helpers

    task automatic send_item(input logic [15:0] feat, input logic [15:0] exp_val);
        @(negedge clk);
        in_valid  = 1'b1;
        sepal_len = feat[15:12];
        sepal_wid = feat[11:8];
        petal_len = feat[7:4];
        petal_wid = feat[3:0];
        exp_q.push_back(exp_val);
        sent_q.push_back(cyc);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic model_expect(input logic [15:0] feat, output logic [15:0] exp_val);
        int sp;
        int sc;
        predict_species(feat[15:12], feat[11:8], feat[7:4], feat[3:0], sp, sc);
        exp_val = {sp[3:0], 1'b0, sc[10:0]};
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 4 * iris_nn_pkg::total_latency) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected outputs never arrived", exp_q.size());
            errors++;
            exp_q.delete();
            sent_q.delete();
        end
        idle_cycles(2);
    endtask

    task automatic end_test(input string name);
        $display("Test %s done, %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    ////////////////////
    // Test sequence

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        sepal_len = '0;
        sepal_wid = '0;
        petal_len = '0;
        petal_wid = '0;
        idle_cycles(8);
        rst_n = 1'b1;
        idle_cycles(2);

        // One strobe, one pulse
        seen_before = n_out_seen;
        send_item(stim_table[7][31:16], stim_table[7][15:0]);
        idle_cycles(1);
        wait_drain();
        assert (n_out_seen - seen_before == 1) else begin
            $display("Error: one strobe gave %0d output cycles", n_out_seen - seen_before);
            errors++;
        end
        end_test("latency");

        for (int r = 0; r < n_rows; r++) begin
            model_expect(stim_table[r][31:16], model_val);
            assert (model_val == stim_table[r][15:0]) else begin
                $display("Fail: row %0d model %h, table %h", r, model_val, stim_table[r][15:0]);
                errors++;
            end
            send_item(stim_table[r][31:16], stim_table[r][15:0]);
            idle_cycles(1);
        end
        wait_drain();
        end_test("table");

        for (int r = 0; r < n_rows; r++) begin
            send_item(stim_table[r][31:16], stim_table[r][15:0]);
        end
        idle_cycles(1);
        wait_drain();
        end_test("streaming");

        for (int k = 0; k < n_random; k++) begin
            rand_feat = $random(seed);
            model_expect(rand_feat, model_val);
            send_item(rand_feat, model_val);
            gap = $random(seed) & 3;
            if (gap > 0) begin
                idle_cycles(gap);
            end
        end
        idle_cycles(1);
        wait_drain();
        end_test("random");

        // Items still in the pipeline when reset hits
        for (int r = 0; r < 3; r++) begin
            send_item(stim_table[r][31:16], stim_table[r][15:0]);
        end
        idle_cycles(2);
        rst_n = 1'b0;
        exp_q.delete();
        sent_q.delete();
        seen_before = n_out_seen;
        idle_cycles(2);
        rst_n = 1'b1;
        idle_cycles(iris_nn_pkg::total_latency + 4);
        assert (n_out_seen == seen_before) else begin
            $display("Error: stale items came out after reset");
            errors++;
        end
        send_item(stim_table[10][31:16], stim_table[10][15:0]);
        idle_cycles(1);
        wait_drain();
        end_test("reset");

        $display("Checked %0d outputs, %0d errors", n_checked, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/iris_nn_top.sv
`default_nettype none

module iris_nn_top (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               in_valid,
    input  wire logic [iris_nn_pkg::feat_w-1:0]     sepal_len,
    input  wire logic [iris_nn_pkg::feat_w-1:0]     sepal_wid,
    input  wire logic [iris_nn_pkg::feat_w-1:0]     petal_len,
    input  wire logic [iris_nn_pkg::feat_w-1:0]     petal_wid,
    output logic                                    out_valid,
    output logic [3:0]                              species,
    output logic [iris_nn_pkg::prob_w-1:0]          score
);

    localparam int feat_pad = iris_nn_pkg::act_w - iris_nn_pkg::feat_w - iris_nn_pkg::frac_bits;
    localparam int prob_pad = iris_nn_pkg::act_w - iris_nn_pkg::prob_w;

    logic signed [iris_nn_pkg::act_w-1:0] feat_act [iris_nn_pkg::n_in];
    logic signed [iris_nn_pkg::act_w-1:0] hid_act  [iris_nn_pkg::n_hidden];
    logic [iris_nn_pkg::prob_w-1:0]       hid_prob [iris_nn_pkg::n_hidden];
    logic [iris_nn_pkg::prob_w-1:0]       out_prob [iris_nn_pkg::n_out];
    logic                                 hid_valid;
    logic                                 out_layer_valid;

    // Integer measurement becomes x.0 in fixed point
    assign feat_act[0] = {{feat_pad{1'b0}}, sepal_len, {iris_nn_pkg::frac_bits{1'b0}}};
    assign feat_act[1] = {{feat_pad{1'b0}}, sepal_wid, {iris_nn_pkg::frac_bits{1'b0}}};
    assign feat_act[2] = {{feat_pad{1'b0}}, petal_len, {iris_nn_pkg::frac_bits{1'b0}}};
    assign feat_act[3] = {{feat_pad{1'b0}}, petal_wid, {iris_nn_pkg::frac_bits{1'b0}}};

    ////////////////////
    // Hidden layer

    nn_layer #(
        .layer     (iris_nn_pkg::layer_hidden),
        .n_neurons (iris_nn_pkg::n_hidden)
    ) i_hidden (
        .clk (clk), .rst_n (rst_n), .in_valid (in_valid),
        .act_0 (feat_act[0]), .act_1 (feat_act[1]),
        .act_2 (feat_act[2]), .act_3 (feat_act[3]),
        .out_valid (hid_valid), .prob (hid_prob)
    );

    // Probabilities are non-negative, zero-extend
    generate
        for (genvar i = 0; i < iris_nn_pkg::n_hidden; i++) begin : g_widen
            assign hid_act[i] = {{prob_pad{1'b0}}, hid_prob[i]};
        end
    endgenerate

    ////////////////////
    // Output layer

    nn_layer #(
        .layer     (iris_nn_pkg::layer_output),
        .n_neurons (iris_nn_pkg::n_out)
    ) i_output (
        .clk (clk), .rst_n (rst_n), .in_valid (hid_valid),
        .act_0 (hid_act[0]), .act_1 (hid_act[1]),
        .act_2 (hid_act[2]), .act_3 (hid_act[3]),
        .out_valid (out_layer_valid), .prob (out_prob)
    );

    species_argmax i_argmax (
        .clk (clk), .rst_n (rst_n), .in_valid (out_layer_valid),
        .prob_0 (out_prob[0]), .prob_1 (out_prob[1]), .prob_2 (out_prob[2]),
        .out_valid (out_valid), .species (species), .score (score)
    );

endmodule

`default_nettype wire

// File: hw/species_argmax.sv
`default_nettype none

module species_argmax (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               in_valid,
    input  wire logic [iris_nn_pkg::prob_w-1:0]     prob_0,
    input  wire logic [iris_nn_pkg::prob_w-1:0]     prob_1,
    input  wire logic [iris_nn_pkg::prob_w-1:0]     prob_2,
    output logic                                    out_valid,
    output logic [3:0]                              species,
    output logic [iris_nn_pkg::prob_w-1:0]          score
);

    logic [iris_nn_pkg::prob_w-1:0] best_12;
    logic [iris_nn_pkg::prob_w-1:0] best;
    iris_nn_pkg::species_e          sp_12;
    iris_nn_pkg::species_e          sp;

    // Ties go to the lower index
    always_comb begin
        if (prob_1 >= prob_2) begin
            best_12 = prob_1;
            sp_12   = iris_nn_pkg::versicolor;
        end else begin
            best_12 = prob_2;
            sp_12   = iris_nn_pkg::virginica;
        end
        if (prob_0 >= best_12) begin
            best = prob_0;
            sp   = iris_nn_pkg::setosa;
        end else begin
            best = best_12;
            sp   = sp_12;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        species <= sp;
        score   <= best;
    end

endmodule

`default_nettype wire

// File: hw/nn_layer.sv
`default_nettype none

module nn_layer #(
    parameter iris_nn_pkg::layer_e layer     = iris_nn_pkg::layer_hidden,
    parameter int                  n_neurons = 4
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 in_valid,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_0,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_1,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_2,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_3,
    output logic                                      out_valid,
    output logic [iris_nn_pkg::prob_w-1:0]            prob [n_neurons]
);

    // MAC stages plus the sigmoid register
    localparam int lat = iris_nn_pkg::mac_latency + iris_nn_pkg::sig_latency;

    logic signed [iris_nn_pkg::act_w-1:0] sum [n_neurons];
    logic [lat-1:0]                       valid_sr;

    ////////////////////
    // Neurons

    generate
        for (genvar n = 0; n < n_neurons; n++) begin : g_neuron
            neuron_mac #(
                .layer (layer),
                .row   (n)
            ) i_mac (
                .clk   (clk),
                .rst_n (rst_n),
                .act_0 (act_0),
                .act_1 (act_1),
                .act_2 (act_2),
                .act_3 (act_3),
                .sum   (sum[n])
            );

            sigmoid_plan i_sig (
                .clk (clk),
                .x   (sum[n]),
                .y   (prob[n])
            );
        end
    endgenerate

    // Valid follows the data through the same number of registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[lat-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[lat-1];

endmodule

`default_nettype wire

// File: hw/sigmoid_plan.sv
`default_nettype none

module sigmoid_plan (
    input  wire logic                                 clk,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] x,
    output logic [iris_nn_pkg::prob_w-1:0]            y
);

    logic [iris_nn_pkg::act_w-1:0]  mag;
    logic [iris_nn_pkg::act_w-1:0]  seg;
    logic [iris_nn_pkg::prob_w-1:0] pos;
    logic                           neg;

    assign neg = x[iris_nn_pkg::act_w-1];

    // |x|, never the most negative value here
    assign mag = neg ? -x : x;

    ////////////////////
    // Positive half of the curve

    always_comb begin
        if (mag >= iris_nn_pkg::sig_brk_3) begin
            // Saturated
            seg = {{(iris_nn_pkg::act_w - iris_nn_pkg::prob_w){1'b0}}, iris_nn_pkg::prob_one};
        end else if (mag >= iris_nn_pkg::sig_brk_2) begin
            // Slope 1/32
            seg = (mag >> 5) + iris_nn_pkg::sig_off_2;
        end else if (mag >= iris_nn_pkg::sig_brk_1) begin
            // Slope 1/8
            seg = (mag >> 3) + iris_nn_pkg::sig_off_1;
        end else begin
            // Slope 1/4 around zero
            seg = (mag >> 2) + iris_nn_pkg::sig_off_0;
        end
        pos = seg[iris_nn_pkg::prob_w-1:0];
    end

    // Mirror about 0.5 for negative inputs
    always_ff @(posedge clk) begin
        if (neg) begin
            y <= iris_nn_pkg::prob_one - pos;
        end else begin
            y <= pos;
        end
    end

endmodule

`default_nettype wire

// File: hw/neuron_mac.sv
`default_nettype none

module neuron_mac #(
    parameter iris_nn_pkg::layer_e layer = iris_nn_pkg::layer_hidden,
    parameter int                  row   = 0
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_0,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_1,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_2,
    input  wire logic signed [iris_nn_pkg::act_w-1:0] act_3,
    output logic signed [iris_nn_pkg::act_w-1:0]      sum
);

    localparam int prod_w = iris_nn_pkg::weight_w + iris_nn_pkg::act_w;

    logic signed [iris_nn_pkg::weight_w-1:0] w_row [iris_nn_pkg::n_in];
    logic signed [iris_nn_pkg::weight_w-1:0] bias;
    logic signed [iris_nn_pkg::act_w-1:0]    act [iris_nn_pkg::n_in];
    logic signed [prod_w-1:0]                prod_shift [iris_nn_pkg::n_in];
    logic signed [iris_nn_pkg::act_w-1:0]    prod_q [iris_nn_pkg::n_in];
    logic signed [iris_nn_pkg::act_w-1:0]    acc;

    // Pick this neuron's row of weights
    generate
        if (layer == iris_nn_pkg::layer_hidden) begin : g_hidden
            assign w_row = iris_nn_pkg::hidden_w[row];
            assign bias  = iris_nn_pkg::hidden_b[row];
        end else begin : g_output
            assign w_row = iris_nn_pkg::output_w[row];
            assign bias  = iris_nn_pkg::output_b[row];
        end
    endgenerate

    assign act[0] = act_0;
    assign act[1] = act_1;
    assign act[2] = act_2;
    assign act[3] = act_3;

    ////////////////////
    // Stage 1: products

    // Full-width product, then floor back to 10 fraction bits
    always_comb begin
        for (int i = 0; i < iris_nn_pkg::n_in; i++) begin
            prod_shift[i] = (w_row[i] * act[i]) >>> iris_nn_pkg::frac_bits;
        end
    end

    ////////////////////
    // Stage 2: sum plus bias

    always_comb begin
        acc = bias;
        for (int i = 0; i < iris_nn_pkg::n_in; i++) begin
            acc = acc + prod_q[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < iris_nn_pkg::n_in; i++) begin
                prod_q[i] <= '0;
            end
            sum <= '0;
        end else begin
            for (int i = 0; i < iris_nn_pkg::n_in; i++) begin
                prod_q[i] <= prod_shift[i][iris_nn_pkg::act_w-1:0];
            end
            sum <= acc;
        end
    end

endmodule

`default_nettype wire

// File: hw/iris_nn_pkg.sv
`default_nettype none

package iris_nn_pkg;

    ////////////////////
    // Widths

    // Raw measurement from the sensor side
    localparam int feat_w    = 4;
    localparam int frac_bits = 10;
    localparam int weight_w  = 16;
    // Wide enough that no weighted sum can overflow
    localparam int act_w     = 24;
    // 0 to 1024 inclusive
    localparam int prob_w    = 11;

    localparam int n_in     = 4;
    localparam int n_hidden = 4;
    localparam int n_out    = 3;

    ////////////////////
    // Trained network, rounded to 1/1024

    localparam logic signed [weight_w-1:0] hidden_w [n_hidden][n_in] = '{
        '{  4096,   152, 13805,  7032 },
        '{ -2170,  5829, -6716, -6711 },
        '{ -6373,  -260, 12796,  6749 },
        '{ -4363,   258,  8743,  4187 }
    };

    localparam logic signed [weight_w-1:0] hidden_b [n_hidden] = '{
        -9996, 1373, -9279, -6392
    };

    // Rows are setosa, versicolor, virginica
    localparam logic signed [weight_w-1:0] output_w [n_out][n_hidden] = '{
        '{ -3021,   8552, -4527, -3163 },
        '{ -8026, -12568, -6552, -3830 },
        '{  7231,  -4009,  7569,  5084 }
    };

    localparam logic signed [weight_w-1:0] output_b [n_out] = '{
        -3513, 7825, -8361
    };

    typedef enum logic {
        layer_hidden,
        layer_output
    } layer_e;

    typedef enum logic [3:0] {
        setosa     = 4'd0,
        versicolor = 4'd1,
        virginica  = 4'd2
    } species_e;

    ////////////////////
    // Sigmoid segments

    // Breakpoints at 1.0, 2.375 and 5.0
    localparam logic [act_w-1:0] sig_brk_1 = 24'd1024;
    localparam logic [act_w-1:0] sig_brk_2 = 24'd2432;
    localparam logic [act_w-1:0] sig_brk_3 = 24'd5120;

    // Offsets of the three sloped segments
    localparam logic [act_w-1:0] sig_off_0 = 24'd512;
    localparam logic [act_w-1:0] sig_off_1 = 24'd640;
    localparam logic [act_w-1:0] sig_off_2 = 24'd864;
    localparam logic [prob_w-1:0] prob_one = 11'd1024;

    ////////////////////
    // Pipeline latencies

    localparam int mac_latency    = 2;
    localparam int sig_latency    = 1;
    localparam int argmax_latency = 1;
    localparam int total_latency  = 2 * (mac_latency + sig_latency) + argmax_latency;

endpackage

`default_nettype wire
